/* hdl/rmii_pkg.sv */
// Shared widths, bus address map, register indices, structs and FSM states for the RMII framer
`default_nettype none

package rmii_pkg;

   localparam int BUF_BYTES_LP = 2048;   // Bytes in each frame buffer

   typedef logic [10:0] byte_addr_t;     // Byte address into a buffer
   typedef logic [8:0]  word_addr_t;     // Word address into a buffer
   typedef logic [10:0] frame_len_t;     // Frame length in bytes
   typedef logic [7:0]  byte_t;
   typedef logic [31:0] word_t;
   typedef logic [1:0]  dibit_t;         // One RMII transfer

   // Regions decoded from bus address bits 12:11
   localparam logic [1:0] REGION_RXBUF_LP = 2'b00;
   localparam logic [1:0] REGION_REGS_LP  = 2'b01;
   localparam logic [1:0] REGION_TXBUF_LP = 2'b10;

   // Register indices from bus address bits 5:2
   localparam logic [3:0] REG_CTRL_LP = 4'd0;
   localparam logic [3:0] REG_TX_LP   = 4'd1;
   localparam logic [3:0] REG_MDIO_LP = 4'd2;
   localparam logic [3:0] REG_RX_LP   = 4'd3;

   localparam frame_len_t PREAMBLE_BYTES_LP = 11'd7;
   localparam byte_t      PREAMBLE_VAL_LP   = 8'h55;
   localparam byte_t      SFD_LP            = 8'hD5;
   localparam frame_len_t IFG_BYTES_LP      = 11'd12;   // Inter-frame gap

   typedef struct packed {
      logic        ce;
      logic        we;
      logic        sel;
      logic [12:0] addr;    // Byte address
      word_t       wdata;
      logic [3:0]  be;      // Byte enables for writes
   } bus_req_t;

   typedef struct packed {
      logic   en;
      dibit_t txd;
   } rmii_tx_t;

   typedef struct packed {
      logic phy_rst;
      logic mdio_oe;
      logic mdio_out;
      logic mdc;
   } mdio_out_t;

   typedef enum logic [1:0] {IDLE, PREAMBLE, DATA, GAP} tx_state_t;

   typedef enum logic {HUNT, FRAME} rx_state_t;

endpackage

`default_nettype wire

/* hdl/frame_buffer.sv */
// Frame memory with a byte port for the framer and a word port for the bus, one per direction
`default_nettype none

module frame_buffer import rmii_pkg::*;
(
   input  logic       clk_rmii,
   input  bus_req_t   bus_i,
   input  logic       region_hit_i,
   input  byte_addr_t byte_addr_i,
   input  logic       byte_we_i,
   input  byte_t      byte_wdata_i,
   output byte_t      byte_rdata_o,
   output word_t      word_rdata_o
);

   word_t      mem [BUF_BYTES_LP/4];
   word_addr_t byte_word;
   word_addr_t bus_word;
   logic       bus_wr;
   logic       bus_rd;

   assign byte_word = byte_addr_i[10:2];
   assign bus_word  = bus_i.addr[10:2];
   assign bus_wr    = bus_i.ce & bus_i.sel & bus_i.we & region_hit_i;
   assign bus_rd    = bus_i.ce & bus_i.sel & ~bus_i.we & region_hit_i;

   always_ff @(posedge clk_rmii)
   begin
      if (byte_we_i)
         mem[byte_word][{byte_addr_i[1:0], 3'b000} +: 8] <= byte_wdata_i;   // Little-endian lane
      for (int j = 0; j < 4; j++)
      begin
         if (bus_wr && bus_i.be[j])
            mem[bus_word][8*j +: 8] <= bus_i.wdata[8*j +: 8];
      end
      byte_rdata_o <= mem[byte_word][{byte_addr_i[1:0], 3'b000} +: 8];   // Always reading
      if (bus_rd)
         word_rdata_o <= mem[bus_word];   // Held until the next bus read
   end

   // Software must not touch the word the framer is writing
   assert property (@(posedge clk_rmii) !(byte_we_i && bus_wr && (byte_word == bus_word)))
      else $error("frame_buffer: framer and bus write the same word");

endmodule

`default_nettype wire

/* hdl/rmii_rx_deserializer.sv */
// RMII receive path: finds the delimiter, packs dibits into bytes and writes the receive buffer
`default_nettype none

module rmii_rx_deserializer import rmii_pkg::*;
(
   input  logic       clk_rmii,
   input  logic       rstn,
   input  dibit_t     rxd_i,
   input  logic       crs_dv_i,
   input  logic       loopback_i,
   input  rmii_tx_t   tx_loop_i,
   input  logic       rx_hold_i,
   output byte_addr_t wr_addr_o,
   output logic       wr_we_o,
   output byte_t      wr_data_o,
   output logic       rx_done_o,
   output frame_len_t rx_len_o
);

   rx_state_t  state_q;
   dibit_t     dibit;
   logic       carrier;
   byte_t      shift_q;
   byte_t      shift_nxt;
   logic [1:0] dib_cnt_q;
   byte_addr_t cnt_q;
   logic       full_q;
   logic       drop_q;
   logic       sfd_hit;
   logic       byte_done;
   logic       frame_end;

   assign dibit     = loopback_i ? tx_loop_i.txd : rxd_i;
   assign carrier   = loopback_i ? tx_loop_i.en : crs_dv_i;
   assign shift_nxt = {dibit, shift_q[7:2]};   // LSB-first, newest dibit on top
   assign sfd_hit   = carrier && (shift_nxt == SFD_LP);
   assign byte_done = (state_q == FRAME) && carrier && (dib_cnt_q == 2'd3);
   assign frame_end = (state_q == FRAME) && !carrier;

   always_ff @(posedge clk_rmii)
   begin
      if (!rstn)
      begin
         state_q   <= HUNT;
         dib_cnt_q <= 2'd0;
         cnt_q     <= '0;
         full_q    <= 1'b0;
         drop_q    <= 1'b0;
         wr_we_o   <= 1'b0;
         rx_done_o <= 1'b0;
      end
      else
      begin
         wr_we_o   <= byte_done && !full_q;   // Bytes past the buffer end are dropped
         rx_done_o <= frame_end;
         case (state_q)
            HUNT:
            begin
               if (!carrier)
                  drop_q <= 1'b0;   // Line idle, ready for the next frame
               else if (sfd_hit && !drop_q)
               begin
                  if (rx_hold_i)
                     drop_q <= 1'b1;   // Previous frame not yet taken, skip this one
                  else
                  begin
                     state_q   <= FRAME;
                     dib_cnt_q <= 2'd0;
                     cnt_q     <= '0;
                     full_q    <= 1'b0;
                  end
               end
            end
            FRAME:
            begin
               if (frame_end)
                  state_q <= HUNT;
               else
                  dib_cnt_q <= dib_cnt_q + 2'd1;
               if (byte_done)
               begin
                  if (&cnt_q)
                     full_q <= 1'b1;   // Length saturates at the last address
                  else
                     cnt_q <= cnt_q + 1'b1;
               end
            end
            default: state_q <= HUNT;
         endcase
      end
   end

   always_ff @(posedge clk_rmii)
   begin
      shift_q <= shift_nxt;
      if (byte_done)
      begin
         wr_addr_o <= cnt_q;
         wr_data_o <= shift_nxt;
      end
      if (frame_end)
         rx_len_o <= cnt_q;
   end

   // Buffer writes only come out of a frame that was accepted
   assert property (@(posedge clk_rmii) disable iff (!rstn)
                    ((state_q == HUNT) || rx_hold_i) |-> !wr_we_o)
      else $error("rmii_rx_deserializer: buffer write outside an accepted frame");

endmodule

`default_nettype wire

/* hdl/rmii_tx_serializer.sv */
// RMII transmit path: sends preamble, delimiter and buffer bytes as dibits, then the gap
`default_nettype none

module rmii_tx_serializer import rmii_pkg::*;
(
   input  logic       clk_rmii,
   input  logic       rstn,
   input  logic       tx_start_i,
   input  frame_len_t tx_len_i,
   output byte_addr_t rd_addr_o,
   input  byte_t      rd_data_i,
   output rmii_tx_t   tx_o,
   output logic       tx_busy_o
);

   tx_state_t  state_q;
   logic [1:0] dib_cnt_q;     // Dibit within the byte
   frame_len_t byte_cnt_q;    // Byte within the phase
   frame_len_t len_q;
   byte_t      cur_byte;
   dibit_t     cur_dibit;
   logic       sending;
   logic       byte_end;
   logic       phase_end;

   assign tx_busy_o = (state_q != IDLE);
   assign sending   = (state_q == PREAMBLE) || (state_q == DATA);
   assign byte_end  = (dib_cnt_q == 2'd3);

   always_comb
   begin
      if (state_q == DATA)
         cur_byte = rd_data_i;
      else if (byte_cnt_q == PREAMBLE_BYTES_LP)
         cur_byte = SFD_LP;   // Last byte of the preamble phase
      else
         cur_byte = PREAMBLE_VAL_LP;
   end

   assign cur_dibit = cur_byte[{dib_cnt_q, 1'b0} +: 2];   // LSB-first

   always_comb
   begin
      case (state_q)
         PREAMBLE: phase_end = (byte_cnt_q == PREAMBLE_BYTES_LP);
         DATA:     phase_end = (byte_cnt_q == len_q - 1'b1);
         GAP:      phase_end = (byte_cnt_q == IFG_BYTES_LP - 1'b1);
         default:  phase_end = 1'b0;
      endcase
   end

   always_ff @(posedge clk_rmii)
   begin
      if (!rstn)
      begin
         state_q    <= IDLE;
         dib_cnt_q  <= 2'd0;
         byte_cnt_q <= '0;
         tx_o       <= '0;
      end
      else
      begin
         tx_o.en  <= sending;
         tx_o.txd <= sending ? cur_dibit : 2'b00;   // Line held low when idle or in the gap
         if (state_q == IDLE)
         begin
            if (tx_start_i)
            begin
               state_q    <= PREAMBLE;
               dib_cnt_q  <= 2'd0;
               byte_cnt_q <= '0;
            end
         end
         else
         begin
            dib_cnt_q <= dib_cnt_q + 2'd1;
            if (byte_end)
            begin
               if (phase_end)
               begin
                  byte_cnt_q <= '0;
                  case (state_q)
                     PREAMBLE: state_q <= DATA;
                     DATA:     state_q <= GAP;
                     default:  state_q <= IDLE;
                  endcase
               end
               else
                  byte_cnt_q <= byte_cnt_q + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_rmii)
   begin
      if ((state_q == IDLE) && tx_start_i)
      begin
         len_q     <= tx_len_i;
         rd_addr_o <= '0;   // First byte is ready before the delimiter ends
      end
      else if ((state_q == DATA) && (dib_cnt_q == 2'd2))
         rd_addr_o <= rd_addr_o + 1'b1;   // Next byte arrives as this one ends
   end

   // The register block must hold back starts while a frame is in flight
   assert property (@(posedge clk_rmii) disable iff (!rstn) tx_start_i |-> !tx_busy_o)
      else $error("rmii_tx_serializer: start while busy");

endmodule

`default_nettype wire

/* hdl/eth_regs.sv */
// Bus register block: control, transmit start, MDIO bits, receive status, interrupt and read mux
`default_nettype none

module eth_regs import rmii_pkg::*;
(
   input  logic       clk_rmii,
   input  logic       rstn,
   input  bus_req_t   bus_i,
   input  word_t      rxbuf_rdata_i,
   input  word_t      txbuf_rdata_i,
   output word_t      rdata_o,
   input  logic       mdio_i,
   output mdio_out_t  mdio_o,
   output logic       loopback_o,
   output logic       tx_start_o,
   output frame_len_t tx_len_o,
   input  logic       tx_busy_i,
   input  logic       rx_done_i,
   input  frame_len_t rx_len_i,
   output logic       rx_hold_o,
   output logic       eth_irq_o
);

   logic [1:0] region;
   logic [3:0] reg_idx;
   logic       bus_rd;
   logic       regs_wr;
   logic       tx_accept;
   logic       loopback_q;
   logic       irq_en_q;
   logic       sync_q;
   logic       eth_irq_q;
   logic       tx_start_q;
   frame_len_t tx_len_q;
   frame_len_t rx_len_q;
   mdio_out_t  mdio_q;
   logic [1:0] rd_region_q;
   word_t      reg_val;
   word_t      reg_rdata_q;

   assign region  = bus_i.addr[12:11];
   assign reg_idx = bus_i.addr[5:2];
   assign bus_rd  = bus_i.ce & bus_i.sel & ~bus_i.we;
   assign regs_wr = bus_i.ce & bus_i.sel & bus_i.we & (region == REGION_REGS_LP);

   // A start is taken only when idle and nothing is pending
   assign tx_accept = regs_wr && (reg_idx == REG_TX_LP) && (bus_i.wdata[10:0] != '0) &&
                      !tx_busy_i && !tx_start_q;

   assign loopback_o = loopback_q;
   assign tx_start_o = tx_start_q;
   assign tx_len_o   = tx_len_q;
   assign rx_hold_o  = sync_q;
   assign eth_irq_o  = eth_irq_q;
   assign mdio_o     = mdio_q;

   always_ff @(posedge clk_rmii)
   begin
      if (!rstn)
      begin
         loopback_q  <= 1'b0;
         irq_en_q    <= 1'b0;
         sync_q      <= 1'b0;
         eth_irq_q   <= 1'b0;
         tx_start_q  <= 1'b0;
         tx_len_q    <= '0;
         rx_len_q    <= '0;
         mdio_q      <= '0;
         rd_region_q <= 2'b11;   // Reads zero until the first read
      end
      else
      begin
         tx_start_q <= tx_accept;
         eth_irq_q  <= sync_q & irq_en_q;
         if (tx_accept)
            tx_len_q <= bus_i.wdata[10:0];
         if (regs_wr && (reg_idx == REG_CTRL_LP))
            {irq_en_q, loopback_q} <= bus_i.wdata[1:0];
         if (regs_wr && (reg_idx == REG_MDIO_LP))
            mdio_q <= bus_i.wdata[3:0];
         if (rx_done_i)
         begin
            sync_q   <= 1'b1;   // Set wins over a clear in the same cycle
            rx_len_q <= rx_len_i;
         end
         else if (regs_wr && (reg_idx == REG_RX_LP))
            sync_q <= 1'b0;
         if (bus_rd)
            rd_region_q <= region;
      end
   end

   always_comb
   begin
      case (reg_idx)
         REG_CTRL_LP: reg_val = {30'd0, irq_en_q, loopback_q};
         REG_TX_LP:   reg_val = {tx_busy_i | tx_start_q, 20'd0, tx_len_q};
         REG_MDIO_LP: reg_val = {27'd0, mdio_i, mdio_q};
         REG_RX_LP:   reg_val = {eth_irq_q, sync_q, 19'd0, rx_len_q};
         default:     reg_val = '0;
      endcase
   end

   always_ff @(posedge clk_rmii)
   begin
      if (bus_rd && (region == REGION_REGS_LP))
         reg_rdata_q <= reg_val;   // Same latency as the buffer word ports
   end

   always_comb
   begin
      case (rd_region_q)
         REGION_RXBUF_LP: rdata_o = rxbuf_rdata_i;
         REGION_REGS_LP:  rdata_o = reg_rdata_q;
         REGION_TXBUF_LP: rdata_o = txbuf_rdata_i;
         default:         rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/rmii_framer_top.sv */
// Top level of the RMII framer, connecting registers, frame buffers, receiver and transmitter
`default_nettype none

module rmii_framer_top import rmii_pkg::*;
(
   input  logic      clk_rmii,
   input  logic      rstn,
   input  bus_req_t  bus_i,
   output word_t     rdata_o,
   input  dibit_t    rxd_i,
   input  logic      crs_dv_i,
   output dibit_t    txd_o,
   output logic      tx_en_o,
   input  logic      mdio_i,
   output mdio_out_t mdio_o,
   output logic      eth_irq_o
);

   logic       rx_hit;
   logic       tx_hit;
   word_t      rxbuf_word;
   word_t      txbuf_word;
   byte_addr_t rx_wr_addr;
   logic       rx_wr_we;
   byte_t      rx_wr_data;
   logic       rx_done;
   frame_len_t rx_len;
   logic       rx_hold;
   logic       loopback;
   logic       tx_start;
   frame_len_t tx_len;
   logic       tx_busy;
   byte_addr_t tx_rd_addr;
   byte_t      tx_rd_data;
   rmii_tx_t   tx_line;

   assign rx_hit  = (bus_i.addr[12:11] == REGION_RXBUF_LP);
   assign tx_hit  = (bus_i.addr[12:11] == REGION_TXBUF_LP);
   assign txd_o   = tx_line.txd;
   assign tx_en_o = tx_line.en;

   eth_regs u_regs (
      .clk_rmii      (clk_rmii),
      .rstn          (rstn),
      .bus_i         (bus_i),
      .rxbuf_rdata_i (rxbuf_word),
      .txbuf_rdata_i (txbuf_word),
      .rdata_o       (rdata_o),
      .mdio_i        (mdio_i),
      .mdio_o        (mdio_o),
      .loopback_o    (loopback),
      .tx_start_o    (tx_start),
      .tx_len_o      (tx_len),
      .tx_busy_i     (tx_busy),
      .rx_done_i     (rx_done),
      .rx_len_i      (rx_len),
      .rx_hold_o     (rx_hold),
      .eth_irq_o     (eth_irq_o)
   );

   frame_buffer rx_buf (
      .clk_rmii     (clk_rmii),
      .bus_i        (bus_i),
      .region_hit_i (rx_hit),
      .byte_addr_i  (rx_wr_addr),
      .byte_we_i    (rx_wr_we),
      .byte_wdata_i (rx_wr_data),
      .byte_rdata_o (),            // Receiver only writes
      .word_rdata_o (rxbuf_word)
   );

   frame_buffer tx_buf (
      .clk_rmii     (clk_rmii),
      .bus_i        (bus_i),
      .region_hit_i (tx_hit),
      .byte_addr_i  (tx_rd_addr),
      .byte_we_i    (1'b0),        // Transmitter only reads
      .byte_wdata_i (8'h00),
      .byte_rdata_o (tx_rd_data),
      .word_rdata_o (txbuf_word)
   );

   rmii_rx_deserializer u_rx (
      .clk_rmii   (clk_rmii),
      .rstn       (rstn),
      .rxd_i      (rxd_i),
      .crs_dv_i   (crs_dv_i),
      .loopback_i (loopback),
      .tx_loop_i  (tx_line),
      .rx_hold_i  (rx_hold),
      .wr_addr_o  (rx_wr_addr),
      .wr_we_o    (rx_wr_we),
      .wr_data_o  (rx_wr_data),
      .rx_done_o  (rx_done),
      .rx_len_o   (rx_len)
   );

   rmii_tx_serializer u_tx (
      .clk_rmii   (clk_rmii),
      .rstn       (rstn),
      .tx_start_i (tx_start),
      .tx_len_i   (tx_len),
      .rd_addr_o  (tx_rd_addr),
      .rd_data_i  (tx_rd_data),
      .tx_o       (tx_line),
      .tx_busy_o  (tx_busy)
   );

endmodule

`default_nettype wire

/* tb/rmii_framer_tb.sv */
// Self-checking testbench for the RMII framer, built and run by run_sim.sh through the file list
`default_nettype none

module rmii_framer_tb import rmii_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_NS        = 4;
   localparam int NUM_ROWS      = 7;
   localparam int PAY_MAX       = 64;     // Payload bytes generated per row
   localparam int SYNC_POLLS    = 20;
   localparam int IDLE_CYC      = 8;
   localparam int GAP_CYC       = 4 * 12;
   localparam int ROW_MARGIN_NS = 1200;   // Bus traffic around each frame
   localparam int WD_MARGIN_NS  = 2000;
   localparam byte_t PRE_BYTE   = 8'h55;
   localparam byte_t SFD_BYTE   = 8'hD5;

   localparam logic [1:0] MODE_RX   = 2'd0;
   localparam logic [1:0] MODE_TX   = 2'd1;
   localparam logic [1:0] MODE_LOOP = 2'd2;

   localparam logic [12:0] RXBUF_BASE = 13'h0000;
   localparam logic [12:0] TXBUF_BASE = 13'h1000;
   localparam logic [12:0] ADDR_CTRL  = 13'h0800;
   localparam logic [12:0] ADDR_TX    = 13'h0804;
   localparam logic [12:0] ADDR_MDIO  = 13'h0808;
   localparam logic [12:0] ADDR_RX    = 13'h080C;

   typedef struct packed {
      logic [1:0] mode;
      frame_len_t len;
      logic       irq_en;
      logic       clear_sync;   // Write REG_RX before the frame
      logic       exp_sync;
      logic       exp_irq;
   } test_row_t;

   test_row_t rows [NUM_ROWS] = '{
      '{MODE_RX,   11'd16, 1'b1, 1'b1, 1'b1, 1'b1},
      '{MODE_RX,   11'd10, 1'b1, 1'b0, 1'b1, 1'b1},   // Dropped, sync still set
      '{MODE_RX,   11'd10, 1'b0, 1'b1, 1'b1, 1'b0},
      '{MODE_TX,   11'd24, 1'b0, 1'b0, 1'b1, 1'b0},
      '{MODE_LOOP, 11'd20, 1'b1, 1'b1, 1'b1, 1'b1},
      '{MODE_TX,   11'd5,  1'b1, 1'b1, 1'b0, 1'b0},
      '{MODE_RX,   11'd33, 1'b0, 1'b0, 1'b1, 1'b0}
   };

   logic      clk_rmii;
   logic      rstn;
   bus_req_t  bus;
   word_t     rdata;
   dibit_t    rxd;
   logic      crs_dv;
   dibit_t    txd;
   logic      tx_en;
   logic      mdio_in;
   mdio_out_t mdio_out;
   logic      eth_irq;

   byte_t       payload [PAY_MAX];
   byte_t       rx_model [PAY_MAX];   // Expected receive buffer contents
   frame_len_t  len_model = '0;
   logic        sync_model = 1'b0;
   logic [31:0] seed = 32'h0706_acd4;
   int          err_cnt = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   // Line monitor state, updated on falling edges
   int unsigned neg_cnt = 0;
   int unsigned rise_mark = 0;
   logic        en_prev = 1'b0;
   logic        line_done = 1'b0;
   dibit_t      line_q [$];

   rmii_framer_top uut (
      .clk_rmii  (clk_rmii),
      .rstn      (rstn),
      .bus_i     (bus),
      .rdata_o   (rdata),
      .rxd_i     (rxd),
      .crs_dv_i  (crs_dv),
      .txd_o     (txd),
      .tx_en_o   (tx_en),
      .mdio_i    (mdio_in),
      .mdio_o    (mdio_out),
      .eth_irq_o (eth_irq)
   );

   initial
   begin
      clk_rmii = 1'b0;
      forever #(CLK_NS / 2) clk_rmii = ~clk_rmii;
   end

   always @(negedge clk_rmii)
   begin
      neg_cnt = neg_cnt + 1;
      if (tx_en && !en_prev)
         rise_mark = neg_cnt;
      if (tx_en)
         line_q.push_back(txd);
      if (!tx_en && en_prev)
         line_done = 1'b1;
      en_prev = tx_en;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic string mode_name(input logic [1:0] m);
      case (m)
         MODE_RX: return "external rx";
         MODE_TX: return "transmit";
         default: return "loopback";
      endcase
   endfunction

   // Byte i of the frame as it must appear on the line
   function automatic byte_t line_byte(input int i);
      if (i < 7)
         return PRE_BYTE;
      else if (i == 7)
         return SFD_BYTE;
      return payload[i - 8];
   endfunction

   task automatic check_value(input word_t got, input word_t exp, input string what);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic bus_write(input logic [12:0] addr, input word_t data);
      @(posedge clk_rmii);
      bus <= '{ce: 1'b1, we: 1'b1, sel: 1'b1, addr: addr, wdata: data, be: 4'hF};
      @(posedge clk_rmii);
      bus <= '0;
   endtask

   task automatic bus_read(input logic [12:0] addr, output word_t data);
      @(posedge clk_rmii);
      bus <= '{ce: 1'b1, we: 1'b0, sel: 1'b1, addr: addr, wdata: '0, be: 4'h0};
      @(posedge clk_rmii);
      bus <= '0;
      @(negedge clk_rmii);
      data = rdata;   // One cycle after the request edge
   endtask

   task automatic send_line_byte(input byte_t b);
      byte_t sh;
      sh = b;
      for (int d = 0; d < 4; d++)
      begin
         @(posedge clk_rmii);
         rxd    <= sh[1:0];   // LSB-first
         crs_dv <= 1'b1;
         sh     = sh >> 2;
      end
   endtask

   task automatic send_phy_frame(input int n);
      for (int i = 0; i < 8 + n; i++)
         send_line_byte(line_byte(i));
      @(posedge clk_rmii);
      crs_dv <= 1'b0;
      rxd    <= 2'b00;
   endtask

   task automatic run_tx(input int n);
      word_t       v;
      int unsigned wr_mark;
      int          waited;
      byte_t       got;
      for (int k = 0; k < (n + 3) / 4; k++)
         bus_write(TXBUF_BASE + 13'(4 * k),
                   {payload[4*k+3], payload[4*k+2], payload[4*k+1], payload[4*k]});
      line_q.delete();
      line_done = 1'b0;
      bus_write(ADDR_TX, n);
      wr_mark = neg_cnt;
      bus_read(ADDR_TX, v);
      check_value({31'd0, v[31]}, 32'd1, "REG_TX busy during the frame");
      waited = 0;
      while (!line_done && waited < 4 * (8 + n) + 16)
      begin
         @(posedge clk_rmii);
         waited++;
      end
      if (!line_done)
      begin
         $display("ERROR at %0t ns: transmit frame did not end in time", $time);
         err_cnt++;
      end
      else
      begin
         // First high sample is the falling edge after edge n+2
         check_value(32'(rise_mark - wr_mark), 32'd3, "tx_en_o start edge");
         check_value(32'(line_q.size()), 32'(4 * (8 + n)), "tx_en_o length in cycles");
         if (line_q.size() == 4 * (8 + n))
         begin
            for (int i = 0; i < 8 + n; i++)
            begin
               got = {line_q[4*i+3], line_q[4*i+2], line_q[4*i+1], line_q[4*i]};
               check_value({24'd0, got}, {24'd0, line_byte(i)}, $sformatf("line byte %0d", i));
            end
         end
      end
      bus_read(ADDR_TX, v);
      check_value({31'd0, v[31]}, 32'd1, "REG_TX busy in the gap");
      repeat (GAP_CYC) @(posedge clk_rmii);
      bus_read(ADDR_TX, v);
      check_value(v, n, "REG_TX idle with length");
   endtask

   task automatic check_rx_buffer();
      word_t v;
      word_t mask;
      word_t exp;
      for (int k = 0; k < (int'(len_model) + 3) / 4; k++)
      begin
         bus_read(RXBUF_BASE + 13'(4 * k), v);
         mask = '0;
         exp  = '0;
         for (int j = 0; j < 4; j++)
         begin
            if (4 * k + j < int'(len_model))
            begin
               mask = mask | (32'hFF << (8 * j));   // Little-endian lanes
               exp  = exp | (word_t'(rx_model[4*k+j]) << (8 * j));
            end
         end
         check_value(v & mask, exp & mask, $sformatf("rx buffer word %0d", k));
      end
   endtask

   task automatic run_reg_test();
      word_t v;
      int    err_before;
      err_before = err_cnt;
      check_value({30'd0, tx_en, eth_irq}, 32'd0, "tx_en_o and eth_irq_o after reset");
      check_value({28'd0, mdio_out}, 32'd0, "mdio_o after reset");
      bus_read(ADDR_TX, v);
      check_value({31'd0, v[31]}, 32'd0, "REG_TX busy after reset");
      bus_read(ADDR_RX, v);
      check_value({31'd0, v[30]}, 32'd0, "REG_RX sync after reset");
      bus_write(ADDR_CTRL, 32'h3);
      bus_read(ADDR_CTRL, v);
      check_value(v, 32'h3, "REG_CTRL readback");
      bus_write(ADDR_CTRL, 32'h0);
      bus_read(ADDR_CTRL, v);
      check_value(v, 32'h0, "REG_CTRL readback");
      @(posedge clk_rmii);
      mdio_in <= 1'b1;
      bus_write(ADDR_MDIO, 32'hA);
      @(negedge clk_rmii);
      check_value({28'd0, mdio_out}, 32'hA, "mdio_o pins");
      bus_read(ADDR_MDIO, v);
      check_value(v, 32'h1A, "REG_MDIO readback with mdio_i");
      @(posedge clk_rmii);
      mdio_in <= 1'b0;
      bus_write(ADDR_MDIO, 32'h5);
      @(negedge clk_rmii);
      check_value({28'd0, mdio_out}, 32'h5, "mdio_o pins");
      bus_read(ADDR_MDIO, v);
      check_value(v, 32'h05, "REG_MDIO readback with mdio_i");
      tests_run++;
      if (err_cnt != err_before)
         tests_failed++;
      $display("Test 0 registers and MDIO: %s", (err_cnt == err_before) ? "ok" : "FAILED");
   endtask

   task automatic run_row(input int r);
      test_row_t row;
      word_t     v;
      logic      seen;
      logic      take;
      int        err_before;
      row = rows[r];
      err_before = err_cnt;
      for (int i = 0; i < PAY_MAX; i++)
      begin
         seed = lcg_step(seed);
         payload[i] = seed[23:16];
      end
      if (row.clear_sync)
      begin
         bus_write(ADDR_RX, 32'd0);
         sync_model = 1'b0;
         repeat (2) @(posedge clk_rmii);
         @(negedge clk_rmii);
         check_value({31'd0, eth_irq}, 32'd0, "eth_irq_o low after sync clear");
      end
      bus_write(ADDR_CTRL, {30'd0, row.irq_en, row.mode == MODE_LOOP});
      take = !sync_model && (row.mode != MODE_TX);   // Receiver accepts only when sync is clear
      if (row.mode == MODE_RX)
         send_phy_frame(int'(row.len));
      else
         run_tx(int'(row.len));
      if (take)
      begin
         seen = 1'b0;
         for (int i = 0; i < SYNC_POLLS && !seen; i++)
         begin
            bus_read(ADDR_RX, v);
            seen = v[30];
         end
         if (!seen)
         begin
            $display("ERROR at %0t ns: received frame was never reported", $time);
            err_cnt++;
         end
         sync_model = 1'b1;
         len_model  = row.len;
         for (int i = 0; i < int'(row.len); i++)
            rx_model[i] = payload[i];
      end
      else
         repeat (IDLE_CYC) @(posedge clk_rmii);
      repeat (2) @(posedge clk_rmii);
      @(negedge clk_rmii);
      check_value({31'd0, eth_irq}, {31'd0, row.exp_irq}, "eth_irq_o level");
      bus_read(ADDR_RX, v);
      check_value({31'd0, v[31]}, {31'd0, row.exp_irq}, "REG_RX irq");
      check_value({31'd0, v[30]}, {31'd0, row.exp_sync}, "REG_RX sync");
      check_value({21'd0, v[10:0]}, {21'd0, len_model}, "REG_RX length");
      check_rx_buffer();
      tests_run++;
      if (err_cnt != err_before)
         tests_failed++;
      $display("Test %0d %s len %0d: %s", r + 1, mode_name(row.mode), row.len,
               (err_cnt == err_before) ? "ok" : "FAILED");
   endtask

   initial
   begin
      rstn    = 1'b0;
      bus     = '0;
      rxd     = 2'b00;
      crs_dv  = 1'b0;
      mdio_in = 1'b0;
      repeat (4) @(posedge clk_rmii);
      rstn <= 1'b1;
      run_reg_test();
      for (int r = 0; r < NUM_ROWS; r++)
         run_row(r);
      $display("Tests run %0d, tests failed %0d, check errors %0d",
               tests_run, tests_failed, err_cnt);
      if (err_cnt == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   // Frame and gap time of every row plus bus traffic
   initial
   begin
      int unsigned limit_ns;
      limit_ns = WD_MARGIN_NS;
      for (int r = 0; r < NUM_ROWS; r++)
         limit_ns = limit_ns + 4 * (8 + int'(rows[r].len) + 12) * CLK_NS + ROW_MARGIN_NS;
      #(limit_ns);
      $display("Watchdog: the run did not finish within %0d ns", limit_ns);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

/* rmii_framer.f */
hdl/rmii_pkg.sv
hdl/frame_buffer.sv
hdl/rmii_rx_deserializer.sv
hdl/rmii_tx_serializer.sv
hdl/eth_regs.sv
hdl/rmii_framer_top.sv
tb/rmii_framer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the RMII framer testbench with Verilator, runs it and checks the log for failures
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f rmii_framer.f \
   --top-module rmii_framer_tb \
   --Mdir obj_dir \
   -o rmii_framer_sim

if ! ./obj_dir/rmii_framer_sim > "$LOG" 2>&1; then
   cat "$LOG"
   echo "Simulator exited with an error"
   exit 1
fi

cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
   exit 1
fi

exit 0
